// ==== include/rvCfg_cfg.svh ====
`ifndef RVCFG_CFG_SVH
`define RVCFG_CFG_SVH

// core-wide sizes for the rv32i pipeline

// width of a data or instruction word
`define RV_XLEN 32

// memory address width
// counts bytes on the fetch side and words on the data side
`define RV_ADDR_W 12

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// ebreak encoding that stops the core
`define RV_HALT_WORD 32'h0010_0073

`endif

// ==== hdl/rvPkg.sv ====
package rvPkg;
`include "rvCfg_cfg.svh"

   // data or instruction word
   typedef logic [`RV_XLEN-1:0] word_t;

   // architectural register index, x0 reads as zero
   typedef logic [4:0] regIdx_t;

   // byte address for fetch, word address for data
   typedef logic [`RV_ADDR_W-1:0] memAddr_t;

   // alu operations of the supported subset
   typedef enum logic [2:0] {
      aluAdd,
      aluSub,
      aluAnd,
      aluOr,
      aluXor,
      aluSlt
   } aluOp_t;

   // where an ex operand comes from
   typedef enum logic [1:0] {
      fwdRf,
      fwdExMem,
      fwdMemWb
   } fwdSel_t;

   // writeback value source
   typedef enum logic [1:0] {
      wbAlu,
      wbLoad,
      wbLink
   } wbSel_t;

   // what a retiring instruction did
   typedef enum logic [2:0] {
      retNone,
      retRegWrite,
      retStore,
      retBranch,
      retHalt
   } retireKind_t;

endpackage

// ==== hdl/hazardIf.sv ====
`timescale 1ns/1ps

interface hazardIf;
   import rvPkg::*;

   // source indices of the instructions in ex and id
   regIdx_t exRs1;
   regIdx_t exRs2;
   regIdx_t idRs1;
   regIdx_t idRs2;
   // destinations further down the pipe
   regIdx_t exRd;
   logic    exIsLoad;
   regIdx_t memRd;
   logic    memRegWe;
   regIdx_t wbRd;
   logic    wbRegWe;
   // taken branch or jal sitting in ex
   logic    redirect;

   // hazard unit results
   fwdSel_t fwdA;
   fwdSel_t fwdB;
   // id picks up the value being written this cycle
   logic    idFwdA;
   logic    idFwdB;
   logic    stall;
   logic    flush;

   modport datapath (
      output exRs1, exRs2, idRs1, idRs2, exRd, exIsLoad,
      output memRd, memRegWe, wbRd, wbRegWe, redirect,
      input  fwdA, fwdB, idFwdA, idFwdB, stall, flush
   );

   modport hazard (
      input  exRs1, exRs2, idRs1, idRs2, exRd, exIsLoad,
      input  memRd, memRegWe, wbRd, wbRegWe, redirect,
      output fwdA, fwdB, idFwdA, idFwdB, stall, flush
   );

endinterface

// ==== hdl/retireIf.sv ====
`timescale 1ns/1ps

interface retireIf;
   import rvPkg::*;

   // one instruction leaving mem/wb
   logic        valid;
   retireKind_t kind;
   // written value, or store address for stores
   word_t       value;
   logic        branchTaken;

   modport source (
      output valid, kind, value, branchTaken
   );

   modport monitor (
      input valid, kind, value, branchTaken
   );

endinterface

// ==== hdl/instrDecoder.sv ====
`timescale 1ns/1ps
`include "rvCfg_cfg.svh"

module instrDecoder (
   input  rvPkg::word_t   instr,
   output rvPkg::regIdx_t rs1,
   output rvPkg::regIdx_t rs2,
   output rvPkg::regIdx_t rd,
   output rvPkg::word_t   imm,
   output rvPkg::aluOp_t  aluOp,
   output logic           useImm,
   output logic           regWe,
   output logic           memRead,
   output logic           memWrite,
   output logic           isBranch,
   output logic           branchNe,
   output logic           isJump,
   output logic           isHalt,
   output rvPkg::wbSel_t  wbSel
);
   import rvPkg::*;

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;

   assign opcode = instr[6:0];
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];

   // register fields sit at fixed positions in every format
   assign rs1 = instr[19:15];
   assign rs2 = instr[24:20];
   assign rd  = instr[11:7];

   always_comb begin
      // anything not matched below leaves a bubble
      imm      = '0;
      aluOp    = aluAdd;
      useImm   = 1'b0;
      regWe    = 1'b0;
      memRead  = 1'b0;
      memWrite = 1'b0;
      isBranch = 1'b0;
      branchNe = 1'b0;
      isJump   = 1'b0;
      isHalt   = 1'b0;
      wbSel    = wbAlu;
      case (opcode)
         // register-register alu ops
         7'b0110011: begin
            regWe = 1'b1;
            case (funct3)
               3'b000:  aluOp = funct7[5] ? aluSub : aluAdd;
               3'b010:  aluOp = aluSlt;
               3'b100:  aluOp = aluXor;
               3'b110:  aluOp = aluOr;
               3'b111:  aluOp = aluAnd;
               default: regWe = 1'b0;
            endcase
            // only sub may set funct7
            if (funct7 != 7'b0000000 && !(funct7 == 7'b0100000 && funct3 == 3'b000)) begin
               regWe = 1'b0;
            end
         end
         // addi only
         7'b0010011: begin
            imm    = {{20{instr[31]}}, instr[31:20]};
            useImm = 1'b1;
            regWe  = (funct3 == 3'b000);
         end
         // lw, address from the adder
         7'b0000011: begin
            imm     = {{20{instr[31]}}, instr[31:20]};
            useImm  = 1'b1;
            regWe   = (funct3 == 3'b010);
            memRead = (funct3 == 3'b010);
            wbSel   = wbLoad;
         end
         // sw, s-type immediate
         7'b0100011: begin
            imm      = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            useImm   = 1'b1;
            memWrite = (funct3 == 3'b010);
         end
         // beq and bne differ in funct3 bit 0
         7'b1100011: begin
            imm      = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            isBranch = (funct3[2:1] == 2'b00);
            branchNe = funct3[0];
         end
         // jal writes pc+4 to rd
         7'b1101111: begin
            imm    = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            isJump = 1'b1;
            regWe  = 1'b1;
            wbSel  = wbLink;
         end
         // system space, only ebreak is known
         7'b1110011: isHalt = (instr == `RV_HALT_WORD);
         default: ;
      endcase
   end

endmodule

// ==== hdl/rvAlu.sv ====
`timescale 1ns/1ps

module rvAlu (
   input  rvPkg::word_t  opA,
   input  rvPkg::word_t  opB,
   input  rvPkg::aluOp_t op,
   output rvPkg::word_t  result,
   output logic          equal
);
   import rvPkg::*;

   always_comb begin
      case (op)
         aluAdd:  result = opA + opB;
         aluSub:  result = opA - opB;
         aluAnd:  result = opA & opB;
         aluOr:   result = opA | opB;
         aluXor:  result = opA ^ opB;
         // signed compare, result is 0 or 1
         aluSlt:  result = word_t'($signed(opA) < $signed(opB));
         default: result = '0;
      endcase
   end

   // branch comparator, independent of op
   assign equal = (opA == opB);

endmodule

// ==== hdl/hazardUnit.sv ====
`timescale 1ns/1ps

module hazardUnit (
   hazardIf.hazard hz,
   input  logic    CLK,
   input  logic    RSTn
);
   import rvPkg::*;

   // younger producer wins, x0 never forwards
   function automatic fwdSel_t pickFwd(
      input regIdx_t rs,
      input regIdx_t memRd,
      input logic    memWe,
      input regIdx_t wbRd,
      input logic    wbWe
   );
      if (memWe && memRd != '0 && memRd == rs) begin
         return fwdExMem;
      end
      if (wbWe && wbRd != '0 && wbRd == rs) begin
         return fwdMemWb;
      end
      return fwdRf;
   endfunction

   assign hz.fwdA = pickFwd(hz.exRs1, hz.memRd, hz.memRegWe, hz.wbRd, hz.wbRegWe);
   assign hz.fwdB = pickFwd(hz.exRs2, hz.memRd, hz.memRegWe, hz.wbRd, hz.wbRegWe);

   // register file has no internal bypass
   // id takes the wb value when it reads the register being written
   assign hz.idFwdA = hz.wbRegWe && hz.wbRd != '0 && hz.wbRd == hz.idRs1;
   assign hz.idFwdB = hz.wbRegWe && hz.wbRd != '0 && hz.wbRd == hz.idRs2;

   // load data exists only after mem, so the consumer waits a cycle
   assign hz.stall = hz.exIsLoad && hz.exRd != '0 &&
                     (hz.exRd == hz.idRs1 || hz.exRd == hz.idRs2);

   // taken branch or jal in ex squashes if and id
   assign hz.flush = hz.redirect;

   // a load in ex is never the redirecting instruction
   assert property (@(posedge CLK) disable iff (RSTn) !(hz.stall && hz.flush));

   // the bubble behind a stall clears the load from ex
   // so a load-use stall lasts one cycle
   assert property (@(posedge CLK) disable iff (RSTn) hz.stall |=> !hz.stall);

endmodule

// ==== hdl/pipeDatapath.sv ====
`timescale 1ns/1ps
`include "rvCfg_cfg.svh"

module pipeDatapath (
   input  logic            CLK,
   input  logic            RSTn,
   hazardIf.datapath       hz,
   retireIf.source         rt,
   input  logic            frozen,
   output rvPkg::memAddr_t iMemAddr,
   input  rvPkg::word_t    iMemData,
   output rvPkg::memAddr_t dMemAddr,
   output rvPkg::word_t    dMemWrData,
   input  rvPkg::word_t    dMemRdData,
   output logic            dMemWen,
   output rvPkg::regIdx_t  rfRa1,
   output rvPkg::regIdx_t  rfRa2,
   input  rvPkg::word_t    rfRd1,
   input  rvPkg::word_t    rfRd2,
   output logic            rfWe,
   output rvPkg::regIdx_t  rfWa,
   output rvPkg::word_t    rfWd
);
   import rvPkg::*;

   // fetch
   word_t pc;
   logic haltSeen;
   // if/id
   logic ifIdValid;
   word_t ifIdInstr, ifIdPc;
   // id decode outputs
   regIdx_t decRs1, decRs2, decRd;
   word_t decImm, idOpA, idOpB;
   aluOp_t decAluOp;
   wbSel_t decWbSel;
   logic decUseImm, decRegWe, decMemRead, decMemWrite;
   logic decBranch, decBranchNe, decJump, decHalt, idGo;
   // id/ex
   logic idExValid;
   word_t idExPc, idExA, idExB, idExImm;
   regIdx_t idExRs1, idExRs2, idExRd;
   aluOp_t idExAluOp;
   wbSel_t idExWbSel;
   logic idExUseImm, idExRegWe, idExMemRead, idExMemWrite;
   logic idExBranch, idExBranchNe, idExJump, idExHalt;
   // ex
   word_t exOpA, exOpB, exAluB, aluResult, exResult, exTarget;
   logic aluEqual, exTaken;
   retireKind_t exKind;
   // ex/mem
   logic exMemValid, exMemRegWe, exMemMemWrite, exMemTaken;
   word_t exMemResult, exMemStData;
   regIdx_t exMemRd;
   wbSel_t exMemWbSel;
   retireKind_t exMemKind;
   // mem/wb
   logic memWbValid, memWbRegWe, memWbTaken;
   word_t memWbValue;
   regIdx_t memWbRd;
   retireKind_t memWbKind;

   // fetch stage
   assign iMemAddr = pc[`RV_ADDR_W-1:0];

   always_ff @(posedge CLK) begin
      if (RSTn) begin
         pc <= `RV_RESET_PC;
      end else if (hz.flush) begin
         pc <= exTarget;
      end else if (!hz.stall && !haltSeen && !frozen) begin
         pc <= pc + 32'd4;
      end
   end

   // decode stage
   instrDecoder iDecoder (
      .instr    (ifIdInstr),
      .rs1      (decRs1),
      .rs2      (decRs2),
      .rd       (decRd),
      .imm      (decImm),
      .aluOp    (decAluOp),
      .useImm   (decUseImm),
      .regWe    (decRegWe),
      .memRead  (decMemRead),
      .memWrite (decMemWrite),
      .isBranch (decBranch),
      .branchNe (decBranchNe),
      .isJump   (decJump),
      .isHalt   (decHalt),
      .wbSel    (decWbSel)
   );

   assign rfRa1 = decRs1;
   assign rfRa2 = decRs2;
   assign hz.idRs1 = decRs1;
   assign hz.idRs2 = decRs2;
   // same-cycle write from wb
   assign idOpA = hz.idFwdA ? memWbValue : rfRd1;
   assign idOpB = hz.idFwdB ? memWbValue : rfRd2;

   // nothing younger than ebreak enters ex
   assign idGo = ifIdValid && !hz.stall && !hz.flush && !haltSeen;

   // execute stage
   assign exOpA = (hz.fwdA == fwdExMem) ? exMemResult :
                  (hz.fwdA == fwdMemWb) ? memWbValue : idExA;
   assign exOpB = (hz.fwdB == fwdExMem) ? exMemResult :
                  (hz.fwdB == fwdMemWb) ? memWbValue : idExB;
   assign exAluB = idExUseImm ? idExImm : exOpB;

   rvAlu iAlu (
      .opA    (exOpA),
      .opB    (exAluB),
      .op     (idExAluOp),
      .result (aluResult),
      .equal  (aluEqual)
   );

   // jal links pc+4 here so ex/mem forwarding sees the final value
   assign exResult = (idExWbSel == wbLink) ? idExPc + 32'd4 : aluResult;
   assign exTarget = idExPc + idExImm;
   assign exTaken = idExValid && (idExJump || (idExBranch && (aluEqual != idExBranchNe)));

   always_comb begin
      if (idExHalt) begin
         exKind = retHalt;
      end else if (idExMemWrite) begin
         exKind = retStore;
      end else if (idExBranch) begin
         exKind = retBranch;
      end else if (idExRegWe) begin
         exKind = retRegWrite;
      end else begin
         exKind = retNone;
      end
   end

   assign hz.exRs1 = idExRs1;
   assign hz.exRs2 = idExRs2;
   assign hz.exRd = idExRd;
   assign hz.exIsLoad = idExValid && idExMemRead;
   assign hz.redirect = exTaken;

   // memory stage, data side is word addressed
   assign dMemAddr = exMemResult[`RV_ADDR_W+1:2];
   assign dMemWrData = exMemStData;
   assign dMemWen = exMemValid && exMemMemWrite && !frozen;
   assign hz.memRd = exMemRd;
   assign hz.memRegWe = exMemValid && exMemRegWe;

   // writeback stage
   assign rfWe = memWbValid && memWbRegWe && memWbRd != '0 && !frozen;
   assign rfWa = memWbRd;
   assign rfWd = memWbValue;
   assign hz.wbRd = memWbRd;
   assign hz.wbRegWe = memWbValid && memWbRegWe;

   assign rt.valid = memWbValid;
   assign rt.kind = memWbKind;
   assign rt.value = memWbValue;
   assign rt.branchTaken = memWbTaken;

   // valid bits and halt tracking
   always_ff @(posedge CLK) begin
      if (RSTn) begin
         ifIdValid  <= 1'b0;
         idExValid  <= 1'b0;
         exMemValid <= 1'b0;
         memWbValid <= 1'b0;
         haltSeen   <= 1'b0;
      end else begin
         if (hz.flush) begin
            ifIdValid <= 1'b0;
         end else if (!hz.stall) begin
            ifIdValid <= 1'b1;
         end
         idExValid  <= idGo;
         exMemValid <= idExValid;
         memWbValid <= exMemValid;
         if (idGo && decHalt) begin
            haltSeen <= 1'b1;
         end
      end
   end

   // payload, bubbles are marked by the valid bits alone
   always_ff @(posedge CLK) begin
      if (!hz.stall) begin
         ifIdInstr <= iMemData;
         ifIdPc    <= pc;
      end
      idExPc       <= ifIdPc;
      idExA        <= idOpA;
      idExB        <= idOpB;
      idExImm      <= decImm;
      idExRs1      <= decRs1;
      idExRs2      <= decRs2;
      idExRd       <= decRd;
      idExAluOp    <= decAluOp;
      idExWbSel    <= decWbSel;
      idExUseImm   <= decUseImm;
      idExRegWe    <= decRegWe;
      idExMemRead  <= decMemRead;
      idExMemWrite <= decMemWrite;
      idExBranch   <= decBranch;
      idExBranchNe <= decBranchNe;
      idExJump     <= decJump;
      idExHalt     <= decHalt;
      // ex/mem
      exMemResult   <= exResult;
      exMemStData   <= exOpB;
      exMemRd       <= idExRd;
      exMemRegWe    <= idExRegWe;
      exMemMemWrite <= idExMemWrite;
      exMemTaken    <= exTaken;
      exMemWbSel    <= idExWbSel;
      exMemKind     <= exKind;
      // mem/wb, load data picked here
      memWbValue <= (exMemWbSel == wbLoad) ? dMemRdData : exMemResult;
      memWbRd    <= exMemRd;
      memWbRegWe <= exMemRegWe;
      memWbTaken <= exMemTaken;
      memWbKind  <= exMemKind;
   end

   // a held reset keeps memory and register file untouched
   assert property (@(posedge CLK) RSTn && $past(RSTn) |-> !dMemWen && !rfWe);

endmodule

// ==== hdl/retireMonitor.sv ====
`timescale 1ns/1ps

module retireMonitor (
   input  logic         CLK,
   input  logic         RSTn,
   retireIf.monitor     rt,
   output rvPkg::word_t numInst,
   output logic         halt,
   output rvPkg::word_t outputPort
);
   import rvPkg::*;

   // ebreak counts as a retired instruction too
   always_ff @(posedge CLK) begin
      if (RSTn) begin
         numInst <= '0;
         halt    <= 1'b0;
      end else if (rt.valid) begin
         numInst <= numInst + 32'd1;
         if (rt.kind == retHalt) begin
            halt <= 1'b1;
         end
      end
   end

   // observation port, one word per retirement
   always_comb begin
      case (rt.kind)
         retRegWrite: outputPort = rt.value;
         retStore:    outputPort = rt.value;
         retBranch:   outputPort = word_t'(rt.branchTaken);
         default:     outputPort = '0;
      endcase
      if (!rt.valid) begin
         outputPort = '0;
      end
   end

   // only one ebreak ever retires
   assert property (@(posedge CLK) disable iff (RSTn)
      (rt.valid && rt.kind == retHalt) |-> !halt);

   // the pipe behind ebreak holds nothing that could still retire
   assert property (@(posedge CLK) disable iff (RSTn) halt |=> $stable(numInst));

endmodule

// ==== hdl/riscvTop.sv ====
`timescale 1ns/1ps

module riscvTop (
   input  logic            CLK,
   input  logic            RSTn,
   // instruction memory
   output rvPkg::memAddr_t iMemAddr,
   input  rvPkg::word_t    iMemData,
   // data memory
   output rvPkg::memAddr_t dMemAddr,
   output rvPkg::word_t    dMemWrData,
   input  rvPkg::word_t    dMemRdData,
   output logic            dMemWen,
   // register file
   output rvPkg::regIdx_t  rfRa1,
   output rvPkg::regIdx_t  rfRa2,
   input  rvPkg::word_t    rfRd1,
   input  rvPkg::word_t    rfRd2,
   output logic            rfWe,
   output rvPkg::regIdx_t  rfWa,
   output rvPkg::word_t    rfWd,
   // status and observation
   output rvPkg::word_t    numInst,
   output logic            halt,
   output rvPkg::word_t    outputPort
);

   hazardIf hzBus ();
   retireIf rtBus ();

   pipeDatapath iDatapath (
      .CLK        (CLK),
      .RSTn       (RSTn),
      .hz         (hzBus.datapath),
      .rt         (rtBus.source),
      // halt stops fetch and strobes
      .frozen     (halt),
      .iMemAddr   (iMemAddr),
      .iMemData   (iMemData),
      .dMemAddr   (dMemAddr),
      .dMemWrData (dMemWrData),
      .dMemRdData (dMemRdData),
      .dMemWen    (dMemWen),
      .rfRa1      (rfRa1),
      .rfRa2      (rfRa2),
      .rfRd1      (rfRd1),
      .rfRd2      (rfRd2),
      .rfWe       (rfWe),
      .rfWa       (rfWa),
      .rfWd       (rfWd)
   );

   hazardUnit iHazard (
      .hz   (hzBus.hazard),
      .CLK  (CLK),
      .RSTn (RSTn)
   );

   retireMonitor iMonitor (
      .CLK        (CLK),
      .RSTn       (RSTn),
      .rt         (rtBus.monitor),
      .numInst    (numInst),
      .halt       (halt),
      .outputPort (outputPort)
   );

endmodule

// ==== tb/tbMemModel.sv ====
`timescale 1ns/1ps
`include "rvCfg_cfg.svh"

module tbMemModel (
   input  logic            CLK,
   input  rvPkg::memAddr_t iMemAddr,
   output rvPkg::word_t    iMemData,
   input  rvPkg::memAddr_t dMemAddr,
   input  rvPkg::word_t    dMemWrData,
   output rvPkg::word_t    dMemRdData,
   input  logic            dMemWen,
   input  rvPkg::regIdx_t  rfRa1,
   input  rvPkg::regIdx_t  rfRa2,
   output rvPkg::word_t    rfRd1,
   output rvPkg::word_t    rfRd2,
   input  logic            rfWe,
   input  rvPkg::regIdx_t  rfWa,
   input  rvPkg::word_t    rfWd
);
   import rvPkg::*;

   // fetch side is byte addressed, one word per four bytes
   word_t imem [0:(1 << (`RV_ADDR_W - 2)) - 1];
   word_t dmem [0:(1 << `RV_ADDR_W) - 1];
   word_t regs [0:31];

   // combinational reads
   assign iMemData   = imem[iMemAddr[`RV_ADDR_W-1:2]];
   assign dMemRdData = dmem[dMemAddr];
   // x0 reads as zero
   assign rfRd1 = (rfRa1 == '0) ? '0 : regs[rfRa1];
   assign rfRd2 = (rfRa2 == '0) ? '0 : regs[rfRa2];

   // writes land on the rising edge
   always @(posedge CLK) begin
      if (dMemWen) begin
         dmem[dMemAddr] <= dMemWrData;
      end
      if (rfWe && rfWa != '0) begin
         regs[rfWa] <= rfWd;
      end
   end

   // empty fetch slots hold ebreak so a runaway pc still halts
   task automatic clearAll();
      for (int i = 0; i < (1 << (`RV_ADDR_W - 2)); i++) begin
         imem[i] <= `RV_HALT_WORD;
      end
      // each data word carries its own address
      for (int i = 0; i < (1 << `RV_ADDR_W); i++) begin
         dmem[i] <= {20'hDA7A5, memAddr_t'(i)};
      end
      for (int i = 0; i < 32; i++) begin
         regs[i] <= '0;
      end
   endtask

   // one program word at word index idx
   task automatic putInstr(input int idx, input word_t w);
      imem[idx] <= w;
   endtask

endmodule

// ==== tb/tbRiscv.sv ====
`timescale 1ns/1ps
`include "rvCfg_cfg.svh"

module tbRiscv;
   import rvPkg::*;

   localparam int clkPeriod   = 8;
   localparam int resetCycles = 10;
   localparam int haltBudget  = 300;
   localparam int holdCycles  = 20;
   localparam int numTests    = 5;
   // every test gets a reset, a full run budget and the post-halt window
   localparam int watchdogNs  = numTests * (resetCycles + haltBudget + holdCycles) * clkPeriod;

   logic     CLK;
   logic     RSTn;
   memAddr_t iMemAddr;
   word_t    iMemData;
   memAddr_t dMemAddr;
   word_t    dMemWrData;
   word_t    dMemRdData;
   logic     dMemWen;
   regIdx_t  rfRa1;
   regIdx_t  rfRa2;
   word_t    rfRd1;
   word_t    rfRd2;
   logic     rfWe;
   regIdx_t  rfWa;
   word_t    rfWd;
   word_t    numInst;
   logic     halt;
   word_t    outputPort;

   int          errCount;
   logic [15:0] lfsrState;
   word_t       prog [$];
   // reference state from the instruction-level walk
   word_t       expReg [32];
   word_t       expMem [1 << `RV_ADDR_W];
   word_t       expCount;
   // observation word of each retirement, in program order
   word_t       expOut [$];

   riscvTop i_dut (.*);
   tbMemModel i_mem (.*);

   initial begin
      CLK = 1'b0;
      forever #(clkPeriod / 2) CLK = ~CLK;
   end

   initial begin
      #(watchdogNs);
      $display("run stopped by watchdog after %0d ns, tests did not finish", watchdogNs);
      $display("STATUS: FAIL");
      $finish;
   end

   // galois lfsr, taps for a 16-bit maximal sequence
   function automatic logic [15:0] lfsrStep(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   // one lfsr step per bit taken
   function automatic word_t randBits(input int n);
      word_t v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsrState[0]};
         lfsrState = lfsrStep(lfsrState);
      end
      return v;
   endfunction

   function automatic word_t randImm12();
      word_t v;
      v = randBits(12);
      return {{20{v[11]}}, v[11:0]};
   endfunction

   // rv32i encoders
   function automatic word_t encR(input logic [6:0] f7, input regIdx_t rs2, input regIdx_t rs1,
                                  input logic [2:0] f3, input regIdx_t rd);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic word_t encAddi(input regIdx_t rd, input regIdx_t rs1, input word_t imm);
      return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
   endfunction

   function automatic word_t encLw(input regIdx_t rd, input regIdx_t rs1, input word_t imm);
      return {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
   endfunction

   function automatic word_t encSw(input regIdx_t rs2, input regIdx_t rs1, input word_t imm);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
   endfunction

   // ne selects bne over beq
   function automatic word_t encBr(input logic ne, input regIdx_t rs1, input regIdx_t rs2,
                                   input word_t off);
      return {off[12], off[10:5], rs2, rs1, 2'b00, ne, off[4:1], off[11], 7'b1100011};
   endfunction

   function automatic word_t encJal(input regIdx_t rd, input word_t off);
      return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
   endfunction

   task automatic checkWord(input string what, input word_t got, input word_t exp);
      if (got !== exp) begin
         errCount++;
         $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic checkAddr(input string what, input memAddr_t got, input memAddr_t exp);
      if (got !== exp) begin
         errCount++;
         $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   // walks the loaded program one instruction at a time until ebreak
   task automatic modelRun();
      word_t   pc, ins, a, b, nextPc, immI, immS, immB, immJ, ea, outVal;
      regIdx_t rd;
      int      steps;
      bit      done;
      pc = `RV_RESET_PC;
      done = 1'b0;
      steps = 0;
      expCount = '0;
      expOut.delete();
      for (int r = 0; r < 32; r++) begin
         expReg[r] = '0;
      end
      for (int m = 0; m < (1 << `RV_ADDR_W); m++) begin
         expMem[m] = i_mem.dmem[m];
      end
      while (!done && steps < haltBudget) begin
         ins  = i_mem.imem[pc[`RV_ADDR_W-1:2]];
         rd   = ins[11:7];
         a    = expReg[ins[19:15]];
         b    = expReg[ins[24:20]];
         immI = {{20{ins[31]}}, ins[31:20]};
         immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
         immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
         immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
         nextPc = pc + 32'd4;
         // halt and anything unknown show zero
         outVal = '0;
         expCount++;
         case (ins[6:0])
            7'b0110011: begin
               case (ins[14:12])
                  3'b000:  expReg[rd] = ins[30] ? a - b : a + b;
                  3'b010:  expReg[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                  3'b100:  expReg[rd] = a ^ b;
                  3'b110:  expReg[rd] = a | b;
                  default: expReg[rd] = a & b;
               endcase
               outVal = expReg[rd];
            end
            7'b0010011: begin
               expReg[rd] = a + immI;
               outVal = expReg[rd];
            end
            7'b0000011: begin
               ea = a + immI;
               expReg[rd] = expMem[ea[`RV_ADDR_W+1:2]];
               outVal = expReg[rd];
            end
            // stores show their address
            7'b0100011: begin
               ea = a + immS;
               expMem[ea[`RV_ADDR_W+1:2]] = b;
               outVal = ea;
            end
            // bit 12 turns beq into bne
            7'b1100011: begin
               if ((a == b) != ins[12]) begin
                  nextPc = pc + immB;
                  outVal = 32'd1;
               end
            end
            7'b1101111: begin
               expReg[rd] = pc + 32'd4;
               nextPc = pc + immJ;
               outVal = expReg[rd];
            end
            7'b1110011: done = 1'b1;
            default: ;
         endcase
         expOut.push_back(outVal);
         expReg[0] = '0;
         pc = nextPc;
         steps++;
      end
   endtask

   // also checks outputPort in each cycle that retires an instruction
   task automatic waitForHalt();
      int    n;
      word_t lastOut;
      word_t lastCount;
      n = 0;
      while (halt !== 1'b1 && n < haltBudget) begin
         // numInst moves at the edge that ends the retiring cycle
         lastOut = outputPort;
         lastCount = numInst;
         @(negedge CLK);
         if (numInst !== lastCount && lastCount < expOut.size()) begin
            checkWord($sformatf("outputPort of retirement %0d", lastCount),
                      lastOut, expOut[lastCount]);
         end
         n++;
      end
      if (halt !== 1'b1) begin
         errCount++;
         $display("halt did not rise within %0d cycles after reset", haltBudget);
      end
   endtask

   task automatic checkState();
      for (int r = 1; r < 32; r++) begin
         checkWord($sformatf("register x%0d", r), i_mem.regs[r], expReg[r]);
      end
      for (int m = 0; m < (1 << `RV_ADDR_W); m++) begin
         checkWord($sformatf("data word %0d", m), i_mem.dmem[m], expMem[m]);
      end
      checkWord("numInst at halt", numInst, expCount);
   endtask

   // load prog under reset, build the reference, release and compare at halt
   task automatic runProgram();
      @(negedge CLK);
      RSTn = 1'b1;
      @(negedge CLK);
      i_mem.clearAll();
      foreach (prog[i]) begin
         i_mem.putInstr(i, prog[i]);
      end
      // memory writes settle by the next edge
      @(negedge CLK);
      modelRun();
      repeat (resetCycles - 2) @(negedge CLK);
      RSTn = 1'b0;
      waitForHalt();
      checkState();
   endtask

   task automatic testReset();
      @(negedge CLK);
      RSTn = 1'b1;
      repeat (resetCycles) @(negedge CLK);
      checkWord("rfWe in reset", word_t'(rfWe), '0);
      checkWord("dMemWen in reset", word_t'(dMemWen), '0);
      checkWord("halt in reset", word_t'(halt), '0);
      checkWord("numInst in reset", numInst, '0);
      checkAddr("iMemAddr in reset", iMemAddr, memAddr_t'(`RV_RESET_PC));
   endtask

   // each result feeds the next, covering ex/mem, mem/wb and id forwarding
   task automatic testForwarding();
      word_t immA, immB;
      immA = randImm12();
      immB = randImm12();
      prog.delete();
      prog.push_back(encAddi(5'd1, 5'd0, immA));
      prog.push_back(encAddi(5'd2, 5'd1, immB));
      prog.push_back(encR(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
      prog.push_back(encR(7'h20, 5'd1, 5'd3, 3'b000, 5'd4));
      prog.push_back(encR(7'h00, 5'd2, 5'd4, 3'b100, 5'd5));
      prog.push_back(encR(7'h00, 5'd3, 5'd5, 3'b110, 5'd6));
      prog.push_back(encR(7'h00, 5'd4, 5'd6, 3'b111, 5'd7));
      prog.push_back(encR(7'h00, 5'd3, 5'd4, 3'b010, 5'd8));
      prog.push_back(`RV_HALT_WORD);
      runProgram();
   endtask

   // every load is consumed right away
   task automatic testLoadStore();
      prog.delete();
      prog.push_back(encAddi(5'd1, 5'd0, randImm12()));
      prog.push_back(encAddi(5'd2, 5'd0, 32'd64));
      prog.push_back(encSw(5'd1, 5'd2, 32'd8));
      prog.push_back(encLw(5'd3, 5'd2, 32'd8));
      prog.push_back(encR(7'h00, 5'd1, 5'd3, 3'b000, 5'd4));
      prog.push_back(encSw(5'd4, 5'd2, 32'd12));
      prog.push_back(encLw(5'd5, 5'd2, 32'd12));
      prog.push_back(encSw(5'd5, 5'd2, 32'd16));
      // untouched word comes back as its fill value
      prog.push_back(encLw(5'd6, 5'd2, 32'd20));
      prog.push_back(encAddi(5'd7, 5'd6, 32'd1));
      prog.push_back(`RV_HALT_WORD);
      runProgram();
   endtask

   // x10 to x15 sit in squashed slots and must stay zero
   task automatic testControlFlow();
      prog.delete();
      prog.push_back(encAddi(5'd1, 5'd0, 32'd5));
      prog.push_back(encAddi(5'd2, 5'd0, 32'd5));
      prog.push_back(encAddi(5'd3, 5'd0, 32'd7));
      prog.push_back(encBr(1'b0, 5'd1, 5'd2, 32'd12));
      prog.push_back(encAddi(5'd10, 5'd0, 32'd1));
      prog.push_back(encAddi(5'd11, 5'd0, 32'd2));
      prog.push_back(encBr(1'b1, 5'd1, 5'd2, 32'd8));
      prog.push_back(encAddi(5'd4, 5'd0, 32'd3));
      prog.push_back(encBr(1'b0, 5'd1, 5'd3, 32'd8));
      prog.push_back(encAddi(5'd5, 5'd0, 32'd4));
      prog.push_back(encBr(1'b1, 5'd1, 5'd3, 32'd12));
      prog.push_back(encAddi(5'd12, 5'd0, 32'd1));
      prog.push_back(encAddi(5'd13, 5'd0, 32'd1));
      prog.push_back(encJal(5'd6, 32'd12));
      prog.push_back(encAddi(5'd14, 5'd0, 32'd1));
      prog.push_back(encAddi(5'd15, 5'd0, 32'd1));
      // link value forwarded straight into an add
      prog.push_back(encR(7'h00, 5'd1, 5'd6, 3'b000, 5'd7));
      prog.push_back(`RV_HALT_WORD);
      runProgram();
   endtask

   // countdown loop, then the core must stay quiet after halt
   task automatic testCountHalt();
      memAddr_t pcHeld;
      prog.delete();
      prog.push_back(encAddi(5'd1, 5'd0, 32'd3));
      prog.push_back(encAddi(5'd2, 5'd2, 32'd2));
      prog.push_back(encAddi(5'd1, 5'd1, 32'hFFFF_FFFF));
      prog.push_back(encBr(1'b1, 5'd1, 5'd0, 32'hFFFF_FFF8));
      prog.push_back(`RV_HALT_WORD);
      runProgram();
      pcHeld = iMemAddr;
      repeat (holdCycles) begin
         @(negedge CLK);
         checkWord("halt after halt", word_t'(halt), 32'd1);
         checkWord("rfWe after halt", word_t'(rfWe), '0);
         checkWord("dMemWen after halt", word_t'(dMemWen), '0);
         checkWord("numInst after halt", numInst, expCount);
         checkAddr("iMemAddr after halt", iMemAddr, pcHeld);
      end
   endtask

   initial begin
      RSTn = 1'b1;
      errCount = 0;
      lfsrState = 16'd11;
      i_mem.clearAll();
      testReset();
      testForwarding();
      testLoadStore();
      testControlFlow();
      testCountHalt();
      $display("tests finished with %0d errors", errCount);
      if (errCount == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

// ==== sources.f ====
+incdir+include
hdl/rvPkg.sv
hdl/hazardIf.sv
hdl/retireIf.sv
hdl/instrDecoder.sv
hdl/rvAlu.sv
hdl/hazardUnit.sv
hdl/pipeDatapath.sv
hdl/retireMonitor.sv
hdl/riscvTop.sv
tb/tbMemModel.sv
tb/tbRiscv.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the rv32i pipeline testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tbRiscv -f sources.f -o simRiscv \
   && ./obj_dir/simRiscv | tee sim.log \
   || { echo "build or simulation failed"; exit 1; }
grep -q "STATUS: FAIL" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "no result line in sim.log"; exit 1; }
exit 0
